/* hdl/fpdiv_pkg.sv */
package fpdiv_pkg;

    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);   // round-robin pointer width

    localparam int TAG_W  = 4;
    localparam int MANT_W = 24;   // with hidden bit
    localparam int EXP_W  = 10;   // signed exponent, room for over/underflow
    localparam int BIAS    = 127;
    localparam int EXP_MIN = 1;
    localparam int EXP_MAX = 254;

    localparam int REM_W  = 26;   // partial remainder, two's complement
    localparam int Q_W    = 28;   // 14 radix-4 digits
    localparam int RIDX_W = 7;    // shifted remainder estimate in eighths
    localparam int N_ITER = 14;
    localparam int CNT_W  = $clog2(N_ITER + 1);
    localparam int LANE_LAT = 16; // accept edge to done

    typedef logic [TAG_W-1:0] tag_t;

    typedef struct packed {
        logic [31:0] dividend;
        logic [31:0] divisor;
        tag_t        tag;
    } div_op_t;

    typedef struct packed {
        logic [31:0] quotient;
        tag_t        tag;
    } div_res_t;

    // {sign, magnitude}, magnitude 0..2
    typedef logic [2:0] digit_t;

endpackage

/* hdl/div_lane_if.sv */
`timescale 1ns/1ps

interface div_lane_if;
    import fpdiv_pkg::*;

    logic     start;   // launch pulse from dispatcher
    div_op_t  op;      // valid with start
    logic     busy;    // lane occupied
    logic     done;    // one cycle, res valid
    div_res_t res;

    modport disp (
        output start,
        output op,
        input  busy
    );

    modport lane (
        input  start,
        input  op,
        output busy,
        output done,
        output res
    );

    // collector only watches completions
    modport coll (
        input done,
        input res
    );

endinterface

/* hdl/srt4_qsel.sv */
`timescale 1ns/1ps

module srt4_qsel (
    input  logic [fpdiv_pkg::RIDX_W-1:0] r_idx,  // 4w truncated to 1/8
    input  logic [2:0]                   d_idx,  // divisor bits after the leading one
    output fpdiv_pkg::digit_t            digit
);
    import fpdiv_pkg::*;

    logic signed [RIDX_W-1:0] r_est;
    logic signed [RIDX_W-1:0] m2;   // lower edge of digit 2, in eighths
    logic signed [RIDX_W-1:0] m1;   // lower edge of digit 1

    assign r_est = $signed(r_idx);

    // thresholds per divisor interval [1+i/8, 1+(i+1)/8)
    // negative side mirrors them since the overlap regions are symmetric
    always_comb begin
        case (d_idx)
            3'd0: begin m2 = 7'sd12; m1 = 7'sd4; end
            3'd1: begin m2 = 7'sd14; m1 = 7'sd4; end
            3'd2: begin m2 = 7'sd15; m1 = 7'sd4; end
            3'd3: begin m2 = 7'sd17; m1 = 7'sd6; end
            3'd4: begin m2 = 7'sd18; m1 = 7'sd6; end
            3'd5: begin m2 = 7'sd20; m1 = 7'sd6; end
            3'd6: begin m2 = 7'sd21; m1 = 7'sd8; end
            default: begin m2 = 7'sd23; m1 = 7'sd8; end
        endcase
    end

    always_comb begin
        if (r_est >= m2) begin
            digit = 3'b010;          // +2
        end else if (r_est >= m1) begin
            digit = 3'b001;          // +1
        end else if (r_est >= -m1) begin
            digit = 3'b000;
        end else if (r_est >= -m2) begin
            digit = 3'b101;          // -1
        end else begin
            digit = 3'b110;          // -2
        end
    end

endmodule

/* hdl/fp_unpack.sv */
`timescale 1ns/1ps

module fp_unpack (
    input  logic [31:0]                         dividend,
    input  logic [31:0]                         divisor,
    output logic [fpdiv_pkg::MANT_W-1:0]        mant_a,
    output logic [fpdiv_pkg::MANT_W-1:0]        mant_b,
    output logic                                sign,
    output logic signed [fpdiv_pkg::EXP_W-1:0]  exp_diff
);
    import fpdiv_pkg::*;

    logic [7:0]              exp_a;
    logic [7:0]              exp_b;
    logic signed [EXP_W-1:0] exp_a_s;
    logic signed [EXP_W-1:0] exp_b_s;

    assign exp_a = dividend[30:23];
    assign exp_b = divisor[30:23];

    // normal operands only so the hidden one is always set
    assign mant_a = {1'b1, dividend[22:0]};
    assign mant_b = {1'b1, divisor[22:0]};

    assign sign = dividend[31] ^ divisor[31];

    // zero extend into the wide signed field
    assign exp_a_s = $signed({{(EXP_W-8){1'b0}}, exp_a});
    assign exp_b_s = $signed({{(EXP_W-8){1'b0}}, exp_b});

    // ea - eb + bias spans -126..380
    // lane and packer see the out-of-range cases directly
    assign exp_diff = exp_a_s - exp_b_s + $signed(EXP_W'(BIAS));

endmodule

/* hdl/fp_round_pack.sv */
`timescale 1ns/1ps

module fp_round_pack (
    input  logic                               sign,
    input  logic signed [fpdiv_pkg::EXP_W-1:0] exp,
    input  logic [fpdiv_pkg::MANT_W-1:0]       mant,   // 1.xxx, leading one at top
    input  logic                               guard,
    input  logic                               round,
    input  logic                               sticky,
    output logic [31:0]                        result
);
    import fpdiv_pkg::*;

    logic                    round_up;
    logic                    carry;
    logic [MANT_W-1:0]       mant_r;
    logic [22:0]             frac;
    logic signed [EXP_W-1:0] exp_f;

    // nearest even
    // a tie only rounds up on an odd mantissa
    assign round_up = guard & (round | sticky | mant[0]);

    assign {carry, mant_r} = {1'b0, mant} + {{MANT_W{1'b0}}, round_up};

    // carry means 1.111.. rolled to 10.000..
    assign frac  = carry ? mant_r[MANT_W-1:1] : mant_r[22:0];
    assign exp_f = exp + $signed({{(EXP_W-1){1'b0}}, carry});

    always_comb begin
        if (exp_f < EXP_MIN) begin
            result = {sign, 31'd0};            // flush to signed zero
        end else if (exp_f > EXP_MAX) begin
            result = {sign, 8'hff, 23'd0};     // saturate to infinity
        end else begin
            result = {sign, exp_f[7:0], frac};
        end
    end

endmodule

/* hdl/srt4_lane.sv */
`timescale 1ns/1ps

module srt4_lane (
    input logic      clk,
    input logic      rst,
    div_lane_if.lane lif
);
    import fpdiv_pkg::*;

    // unpack outputs, sampled on start
    logic [MANT_W-1:0]       mant_a;
    logic [MANT_W-1:0]       mant_b;
    logic                    sign_u;
    logic signed [EXP_W-1:0] exp_u;

    logic [MANT_W-1:0]       d_q;        // divisor mantissa
    logic                    sign_q;
    logic signed [EXP_W-1:0] exp_q;
    tag_t                    tag_q;
    logic [REM_W-1:0]        rem_q;      // holds A before the first step
    logic [Q_W-1:0]          q_q;
    logic [Q_W-1:0]          qm_q;       // always q_q - 1
    logic [CNT_W-1:0]        cnt_q;
    logic                    busy_q;
    logic                    done_q;
    div_res_t                res_q;

    logic                    iter;
    logic                    last;
    logic [REM_W+1:0]        y;          // shifted remainder
    logic [REM_W+1:0]        dq;         // 0, D or 2D
    logic [REM_W+1:0]        p_next;
    digit_t                  digit;
    logic [Q_W-1:0]          q_next;
    logic [Q_W-1:0]          qm_next;

    logic [Q_W-1:0]          q_fin;
    logic                    lead;
    logic [MANT_W-1:0]       mant_n;
    logic                    guard;
    logic                    round;
    logic                    sticky;
    logic signed [EXP_W-1:0] exp_n;
    logic [31:0]             word;

    fp_unpack unpack_i (
        .dividend (lif.op.dividend),
        .divisor  (lif.op.divisor),
        .mant_a   (mant_a),
        .mant_b   (mant_b),
        .sign     (sign_u),
        .exp_diff (exp_u)
    );

    assign last = busy_q && (cnt_q == CNT_W'(N_ITER));
    assign iter = busy_q && !last;

    // step 1 reads A as 4*w0 with w0 = A/4, later steps shift by two
    assign y = (cnt_q == '0) ? {{2{rem_q[REM_W-1]}}, rem_q} : {rem_q, 2'b00};

    srt4_qsel qsel_i (
        .r_idx (y[REM_W:REM_W-RIDX_W+1]),
        .d_idx (d_q[MANT_W-2 -: 3]),
        .digit (digit)
    );

    assign dq = digit[1] ? {3'b000, d_q, 1'b0} :
                digit[0] ? {4'b0000, d_q} : '0;
    assign p_next = digit[2] ? y + dq : y - dq;   // negative digit adds

    // on-the-fly conversion of the signed digit
    always_comb begin
        if (digit[2]) begin
            q_next  = {qm_q[Q_W-3:0], 2'd0 - digit[1:0]};
            qm_next = {qm_q[Q_W-3:0], 2'd3 - digit[1:0]};
        end else if (digit[1:0] != 2'd0) begin
            q_next  = {q_q[Q_W-3:0], digit[1:0]};
            qm_next = {q_q[Q_W-3:0], digit[1:0] - 2'd1};
        end else begin
            q_next  = {q_q[Q_W-3:0], 2'b00};
            qm_next = {qm_q[Q_W-3:0], 2'b11};
        end
    end

    // negative final remainder -> quotient one too large
    assign q_fin  = rem_q[REM_W-1] ? qm_q : q_q;
    assign lead   = q_fin[Q_W-2];                    // quotient >= 1
    assign mant_n = lead ? q_fin[Q_W-2 -: MANT_W] : q_fin[Q_W-3 -: MANT_W];
    assign guard  = lead ? q_fin[2] : q_fin[1];
    assign round  = lead ? q_fin[1] : q_fin[0];
    assign sticky = (lead & q_fin[0]) | (|rem_q);
    assign exp_n  = lead ? exp_q : exp_q - 10'sd1;

    fp_round_pack pack_i (
        .sign   (sign_q),
        .exp    (exp_n),
        .mant   (mant_n),
        .guard  (guard),
        .round  (round),
        .sticky (sticky),
        .result (word)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= last;                          // pulse in cycle 16
            if (lif.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (last) begin
                busy_q <= 1'b0;
            end else if (iter) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lif.start) begin
            rem_q  <= {2'b00, mant_a};
            q_q    <= '0;
            qm_q   <= '1;
            d_q    <= mant_b;
            sign_q <= sign_u;
            exp_q  <= exp_u;
            tag_q  <= lif.op.tag;
        end else if (iter) begin
            rem_q <= p_next[REM_W-1:0];              // bounded by 2/3 D
            q_q   <= q_next;
            qm_q  <= qm_next;
        end
        if (last) begin
            res_q.quotient <= word;
            res_q.tag      <= tag_q;
        end
    end

    assign lif.busy = busy_q;
    assign lif.done = done_q;
    assign lif.res  = res_q;

endmodule

/* hdl/div_dispatch.sv */
`timescale 1ns/1ps

module div_dispatch (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [31:0]     in_dividend,
    input  logic [31:0]     in_divisor,
    input  fpdiv_pkg::tag_t in_tag,
    output logic            in_ready,
    div_lane_if.disp        lanes [fpdiv_pkg::NUM_LANES]
);
    import fpdiv_pkg::*;

    logic [NUM_LANES-1:0]  idle;
    logic [NUM_LANES-1:0]  grant;
    logic [LANE_IDX_W-1:0] ptr_q;    // search start
    logic [LANE_IDX_W-1:0] sel;
    logic                  found;
    div_op_t               op;

    assign op = '{dividend: in_dividend, divisor: in_divisor, tag: in_tag};

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_port
        assign idle[i]        = ~lanes[i].busy;
        assign lanes[i].start = grant[i];
        assign lanes[i].op    = op;       // broadcast, start picks the lane
    end

    // first idle lane at or after the pointer
    always_comb begin
        logic [LANE_IDX_W-1:0] idx;
        found = 1'b0;
        sel   = ptr_q;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = ptr_q + LANE_IDX_W'(k);             // wraps
            if (!found && idle[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign in_ready = |idle;
    assign grant    = (in_valid && found) ? (NUM_LANES'(1) << sel) : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr_q <= '0;
        end else if (in_valid && in_ready) begin
            ptr_q <= sel + 1'b1;   // skip past the granted lane
        end
    end

endmodule

/* hdl/div_collect.sv */
`timescale 1ns/1ps

module div_collect (
    input  logic            clk,
    input  logic            rst,
    div_lane_if.coll        lanes [fpdiv_pkg::NUM_LANES],
    output logic            out_valid,
    output logic [31:0]     out_quotient,
    output fpdiv_pkg::tag_t out_tag
);
    import fpdiv_pkg::*;

    logic [NUM_LANES-1:0] done_v;
    div_res_t             res_v [NUM_LANES];
    div_res_t             mux;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_port
        assign done_v[i] = lanes[i].done;
        assign res_v[i]  = lanes[i].res;
    end

    // fixed latency keeps done one-hot, so an AND-OR mux is enough
    always_comb begin
        mux = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            mux = mux | (res_v[i] & {$bits(div_res_t){done_v[i]}});
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= |done_v;      // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (|done_v) begin
            out_quotient <= mux.quotient;
            out_tag      <= mux.tag;
        end
    end

endmodule

/* hdl/fpdiv_array.sv */
`timescale 1ns/1ps

module fpdiv_array (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [31:0]     in_dividend,
    input  logic [31:0]     in_divisor,
    input  fpdiv_pkg::tag_t in_tag,
    output logic            in_ready,
    output logic            out_valid,
    output logic [31:0]     out_quotient,
    output fpdiv_pkg::tag_t out_tag
);
    import fpdiv_pkg::*;

    // one link per lane
    div_lane_if lane_if [NUM_LANES] ();

    div_dispatch dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_dividend (in_dividend),
        .in_divisor  (in_divisor),
        .in_tag      (in_tag),
        .in_ready    (in_ready),
        .lanes       (lane_if)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        srt4_lane lane_i (
            .clk (clk),
            .rst (rst),
            .lif (lane_if[i])
        );
    end

    // registered output stage
    div_collect collect_i (
        .clk          (clk),
        .rst          (rst),
        .lanes        (lane_if),
        .out_valid    (out_valid),
        .out_quotient (out_quotient),
        .out_tag      (out_tag)
    );

endmodule

/* tests/fpdiv_asserts.sv */
`timescale 1ns/1ps

module fpdiv_asserts (
    input logic                            clk,
    input logic                            rst,
    input logic                            in_valid,
    input logic                            in_ready,
    input logic                            out_valid,
    input logic [fpdiv_pkg::NUM_LANES-1:0] lane_done
);
    import fpdiv_pkg::*;

    localparam int OUT_LAT = LANE_LAT + 1;   // lane plus collector register

    // every accept leaves exactly OUT_LAT edges later
    a_latency: assert property (@(posedge clk) disable iff (!rst)
        (in_valid && in_ready) |-> ##OUT_LAT out_valid)
        else $error("accepted operation produced no result after %0d cycles", OUT_LAT);

    // an offer refused by in_ready never shows up at the output
    a_no_phantom: assert property (@(posedge clk) disable iff (!rst)
        out_valid |-> $past(in_valid && in_ready, OUT_LAT))
        else $error("result appeared without a matching accept");

    a_one_done: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(lane_done))
        else $error("more than one lane finished in the same cycle");

    // idle state while reset is held
    a_reset: assert property (@(posedge clk)
        !rst |-> (!out_valid && in_ready && lane_done == '0))
        else $error("control outputs not idle during reset");

endmodule

bind fpdiv_array fpdiv_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .lane_done (collect_i.done_v)
);

/* tests/fpdiv_checker.sv */
`timescale 1ns/1ps

module fpdiv_checker (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  logic [31:0]     in_dividend,
    input  logic [31:0]     in_divisor,
    input  fpdiv_pkg::tag_t in_tag,
    input  logic            in_ready,
    input  logic            out_valid,
    input  logic [31:0]     out_quotient,
    input  fpdiv_pkg::tag_t out_tag,
    output int              error_count,
    output int              missing_count,
    output int              pending
);
    import fpdiv_pkg::*;

    localparam int OUT_LAT = LANE_LAT + 1;

    typedef struct packed {
        logic [31:0] word;
        tag_t        tag;
        logic [31:0] due;    // cycle the result must show up
    } expect_t;

    expect_t     exp_q [$];
    logic [31:0] cyc;        // negedge count

    // long division reference with round to nearest even
    function automatic logic [31:0] expected_quotient(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] num;
        logic [63:0] den;
        logic [63:0] q;
        logic [63:0] r;
        logic [24:0] mant;   // extra bit for the rounding carry
        logic        g;
        logic        rb;
        logic        s;
        logic        sign;
        int          e;
        logic [31:0] word;
        sign = a[31] ^ b[31];
        num  = 64'({1'b1, a[22:0]}) << 26;
        den  = 64'({1'b1, b[22:0]});
        q    = num / den;
        r    = num % den;
        e    = int'(a[30:23]) - int'(b[30:23]) + 127;
        if (q[26]) begin                 // quotient in [1,2)
            mant = {1'b0, q[26:3]};
            g    = q[2];
            rb   = q[1];
            s    = q[0] | (r != 0);
        end else begin                   // below one so shift up a bit
            mant = {1'b0, q[25:2]};
            g    = q[1];
            rb   = q[0];
            s    = (r != 0);
            e    = e - 1;
        end
        if (g && (rb || s || mant[0])) begin
            mant = mant + 25'd1;
        end
        if (mant[24]) begin              // rolled over to 2.0
            mant = mant >> 1;
            e    = e + 1;
        end
        if (e < 1) begin
            word = {sign, 31'd0};
        end else if (e > 254) begin
            word = {sign, 8'hff, 23'd0};
        end else begin
            word = {sign, e[7:0], mant[22:0]};
        end
        return word;
    endfunction

    // lanes still held by earlier accepts (accept cycle >= now - 15)
    function automatic int lanes_in_use(input logic [31:0] now);
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].due >= now + 2) n++;
        end
        return n;
    endfunction

    initial begin
        error_count   = 0;
        missing_count = 0;
        pending       = 0;
        cyc           = 0;
    end

    // mid-cycle sampling while all DUT outputs are settled
    always @(negedge clk) begin : watch
        expect_t head;
        int      busy;
        if (!rst) begin
            if (!in_ready || out_valid) begin
                error_count++;
                $display("error @%0t: in_ready %b out_valid %b during reset",
                         $time, in_ready, out_valid);
            end
        end else begin
            busy = lanes_in_use(cyc);
            if (in_ready !== (busy < NUM_LANES)) begin
                error_count++;
                $display("error @%0t: in_ready %b with %0d lanes busy", $time, in_ready, busy);
            end
            if (exp_q.size() != 0 && exp_q[0].due == cyc && !out_valid) begin
                head = exp_q.pop_front();
                missing_count++;
                $display("missing result at %0t: tag %h was due this cycle", $time, head.tag);
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("unexpected result at %0t: tag %h with nothing pending",
                             $time, out_tag);
                end else begin
                    head = exp_q.pop_front();
                    if (head.due != cyc) begin
                        error_count++;
                        $display("result for tag %h at %0t came %0d cycles off its slot",
                                 head.tag, $time, int'(cyc) - int'(head.due));
                    end
                    if (out_tag !== head.tag) begin
                        error_count++;
                        $display("error @%0t: tag expected %h got %h", $time, head.tag, out_tag);
                    end
                    if (out_quotient !== head.word) begin
                        error_count++;
                        $display("error @%0t: tag %h quotient expected %h got %h",
                                 $time, head.tag, head.word, out_quotient);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back('{word: expected_quotient(in_dividend, in_divisor),
                                  tag:  in_tag,
                                  due:  cyc + OUT_LAT});
            end
        end
        pending = exp_q.size();
        cyc     = cyc + 1;
    end

endmodule

/* tests/fpdiv_array_tb.sv */
`timescale 1ns/1ps

module fpdiv_array_tb;
    import fpdiv_pkg::*;

    localparam int SEED       = 47768;
    localparam int N_OPS      = 400;
    localparam int MAX_CYCLES = N_OPS * 4 + LANE_LAT + 1 + 100;   // 4 cycles per op at full load

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_dividend;
    logic [31:0] in_divisor;
    tag_t        in_tag;
    logic        in_ready;
    logic        out_valid;
    logic [31:0] out_quotient;
    tag_t        out_tag;

    int          error_count;
    int          missing_count;
    int          pending;
    int          cycles;
    tag_t        next_tag;

    fpdiv_array dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_dividend  (in_dividend),
        .in_divisor   (in_divisor),
        .in_tag       (in_tag),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_quotient (out_quotient),
        .out_tag      (out_tag)
    );

    fpdiv_checker check_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_dividend   (in_dividend),
        .in_divisor    (in_divisor),
        .in_tag        (in_tag),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_quotient  (out_quotient),
        .out_tag       (out_tag),
        .error_count   (error_count),
        .missing_count (missing_count),
        .pending       (pending)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] random_normal(input int exp_lo, input int exp_hi);
        logic [7:0] e;
        e = 8'($urandom_range(exp_hi, exp_lo));
        return {1'($urandom), e, 23'($urandom)};
    endfunction

    // mix of directed and random pairs
    task automatic pick_operands(output logic [31:0] a, output logic [31:0] b);
        int kind;
        kind = $urandom_range(9, 0);
        if (kind == 0) begin
            // all-ones divisor puts the quotient a hair above a half-ULP point,
            // exact ties cannot occur between normal operands
            a = {1'($urandom), 8'($urandom_range(150, 100)), 15'd0, 8'($urandom)};
            b = {1'($urandom), 8'($urandom_range(150, 100)), 23'h7fffff};
        end else if (kind == 1) begin
            a = random_normal(60, 190);
            b = {1'($urandom), 8'($urandom_range(150, 100)), 23'd0};   // exact quotient
        end else if (kind < 6) begin
            a = random_normal(100, 154);
            b = random_normal(100, 154);
        end else begin
            a = random_normal(1, 254);     // reaches overflow and underflow
            b = random_normal(1, 254);
        end
    endtask

    // hold the offer until the DUT takes it
    task automatic offer_op(input logic [31:0] a, input logic [31:0] b);
        logic took;
        in_valid    = 1'b1;
        in_dividend = a;
        in_divisor  = b;
        in_tag      = next_tag;
        took        = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_ready;               // stable until the next edge
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        next_tag = next_tag + 1'b1;        // wraps at 16
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        void'($urandom(SEED));
        clk         = 1'b0;
        rst         = 1'b0;
        in_valid    = 1'b0;
        in_dividend = '0;
        in_divisor  = '0;
        in_tag      = '0;
        next_tag    = '0;
        cycles      = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            while ($urandom_range(99, 0) >= 60) begin   // about 60 % offer rate
                @(posedge clk);
                #1;
            end
            pick_operands(a, b);
            offer_op(a, b);
        end
        while (pending != 0) @(posedge clk);
        repeat (LANE_LAT + 4) @(posedge clk);            // room for a stray result
        $display("errors: %0d, missing results: %0d", error_count, missing_count + pending);
        if (error_count == 0 && missing_count == 0 && pending == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* fpdiv_array.f */
hdl/fpdiv_pkg.sv
hdl/div_lane_if.sv
hdl/srt4_qsel.sv
hdl/fp_unpack.sv
hdl/fp_round_pack.sv
hdl/srt4_lane.sv
hdl/div_dispatch.sv
hdl/div_collect.sv
hdl/fpdiv_array.sv
tests/fpdiv_asserts.sv
tests/fpdiv_checker.sv
tests/fpdiv_array_tb.sv

/* Bender.yml */
package:
  name: fpdiv_array

sources:
  - hdl/fpdiv_pkg.sv
  - hdl/div_lane_if.sv
  - hdl/srt4_qsel.sv
  - hdl/fp_unpack.sv
  - hdl/fp_round_pack.sv
  - hdl/srt4_lane.sv
  - hdl/div_dispatch.sv
  - hdl/div_collect.sv
  - hdl/fpdiv_array.sv
  - target: test
    files:
      - tests/fpdiv_asserts.sv
      - tests/fpdiv_checker.sv
      - tests/fpdiv_array_tb.sv
